// ==== Bender.yml ====
package:
  name: pov_tlc5957

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pov_bus_pkg.sv
      - rtl/pov_drv_pkg.sv
      - rtl/pov_apb_regs.sv
      - rtl/tlc_driver_ctrl.sv
      - rtl/slice_buffer.sv
      - rtl/pov_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/tb_pov_top.sv

// ==== bench/tb_pov_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pov_consts.svh"

module tb_pov_top
    import pov_bus_pkg::*;
    import pov_drv_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int IDLE_CYCLES = 600;
    localparam int SEG_LEN     = `POV_SEG_LAST + 1;
    localparam int GROUP_LEN   = `POV_WORD_BITS + 1;
    // Budget in clk cycles, one enabled cycle per two clks
    localparam int SLICE_CLKS  = 2 * (`POV_ROWS * SEG_LEN + IDLE_CYCLES) + 80;
    localparam int CONF_CLKS   = 2 * (`POV_PREP_CYCLES + GROUP_LEN + `POV_WAIT_CYCLES + 10) + 40;
    localparam int FILL_CLKS   = 3 * (`POV_SLICE_WORDS + 60);
    localparam int RUN_CLKS    = FILL_CLKS + 3 * SLICE_CLKS + 3 * CONF_CLKS + 2000;

    logic        clk;
    logic        nrst;
    logic        clk_enable;
    logic        position_sync;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        drv_sclk;
    logic        drv_gclk;
    logic        drv_lat;
    lane_word_t  drv_sin;
    logic        column_ready;
    logic        configured;

    // Reference copies of what the host wrote
    conf_word_t  model_conf;
    lane_word_t  model_buf [`POV_SLICE_WORDS];

    int          err_cnt;
    int          data_errs;
    int          time_errs;
    int          tests_run;
    int          tests_failed;

    pov_top dut_i (
        .clk           (clk),
        .nrst          (nrst),
        .clk_enable    (clk_enable),
        .position_sync (position_sync),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .drv_sclk      (drv_sclk),
        .drv_gclk      (drv_gclk),
        .drv_lat       (drv_lat),
        .drv_sin       (drv_sin),
        .column_ready  (column_ready),
        .configured    (configured)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // SCLK-rate strobe on every second clk
    always @(posedge clk) begin
        clk_enable <= ~clk_enable;
    end

    task automatic report_mismatch(input bit is_data, input string msg);
        err_cnt++;
        if (is_data) begin
            data_errs++;
        end else begin
            time_errs++;
        end
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        time_errs++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input int num, input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    // Outputs settle before the falling edge
    task automatic next_enabled();
        @(negedge clk);
        while (clk_enable !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // Setup phase then access phase, read data taken mid access
    task automatic apb_access(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (pready !== 1'b1 && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (pready !== 1'b1) begin
            report_problem($sformatf("APB access to 0x%02h never got pready", addr));
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, wdata, rd, err);
        if (err !== 1'b0) begin
            report_mismatch(0, $sformatf("pslverr on write to 0x%02h", addr));
        end
    endtask

    task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rd, err);
        if (err !== 1'b0 || rd !== exp) begin
            report_mismatch(0, $sformatf("read 0x%02h got %h err %b, expected %h",
                                         addr, rd, err, exp));
        end
    endtask

    // FCWRTEN, 48 bits with WRTFC on the tail, then the gap before configured
    task automatic check_config_seq();
        int         i;
        bit         found;
        lane_word_t exp_sin;
        found = 1'b0;
        for (i = 0; i < 8 && !found; i++) begin
            next_enabled();
            found = drv_lat && !drv_gclk;
        end
        if (!found) begin
            report_problem("no FCWRTEN LAT after commit");
            return;
        end
        // First LAT cycle already seen
        for (i = 1; i <= `POV_PREP_CYCLES; i++) begin
            next_enabled();
            if ({drv_sclk, drv_gclk, drv_lat, configured} !== {3'b000, 1'b0}
                && i == `POV_PREP_CYCLES) begin
                report_mismatch(0, $sformatf("pause after FCWRTEN, SCLK %b LAT %b",
                                             drv_sclk, drv_lat));
            end
            if ({drv_sclk, drv_gclk, drv_lat, configured} !== 4'b0010
                && i < `POV_PREP_CYCLES) begin
                report_mismatch(0, $sformatf("FCWRTEN cycle %0d SCLK %b GCLK %b LAT %b",
                                             i, drv_sclk, drv_gclk, drv_lat));
            end
        end
        for (i = 0; i < `POV_CONF_BITS; i++) begin
            next_enabled();
            exp_sin = {`POV_LANES{model_conf[`POV_CONF_BITS - 1 - i]}};
            if (drv_sin !== exp_sin) begin
                report_mismatch(1, $sformatf("config bit %0d SIN %h, expected %h",
                                             i, drv_sin, exp_sin));
            end
            if ({drv_sclk, drv_gclk, drv_lat, configured}
                !== {2'b10, i >= `POV_CONF_BITS - `POV_WRTFC_LEN, 1'b0}) begin
                report_mismatch(0, $sformatf("config bit %0d SCLK %b LAT %b configured %b",
                                             i, drv_sclk, drv_lat, configured));
            end
        end
        for (i = 0; i < `POV_WAIT_CYCLES; i++) begin
            next_enabled();
            if ({drv_sclk, drv_lat, configured} !== 3'b000) begin
                report_mismatch(0, $sformatf("WRTFC gap cycle %0d not quiet", i));
            end
        end
        next_enabled();
        if (configured !== 1'b1) begin
            report_mismatch(0, "configured did not rise after the WRTFC gap");
        end
    endtask

    task automatic load_config();
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] half_mask;
        lo        = $urandom;
        hi        = $urandom;
        half_mask = (32'h1 << `POV_CONF_HALF) - 32'h1;
        apb_write(`POV_REG_CONF_LO, lo);
        apb_write(`POV_REG_CONF_HI, hi);
        apb_read_check(`POV_REG_CONF_LO, lo & half_mask);
        apb_read_check(`POV_REG_CONF_HI, hi & half_mask);
        model_conf = {hi[`POV_CONF_HALF-1:0], lo[`POV_CONF_HALF-1:0]};
        apb_write(`POV_REG_CTRL, 32'h1);
        check_config_seq();
        apb_read_check(`POV_REG_STATUS, 32'h1);
    endtask

    task automatic fill_buffer();
        int          i;
        logic [31:0] w;
        apb_write(`POV_REG_BUF_ADDR, 32'h0);
        for (i = 0; i < `POV_SLICE_WORDS; i++) begin
            w = $urandom;
            apb_write(`POV_REG_BUF_DATA, w);
            model_buf[i] = w[`POV_LANES-1:0];
        end
    endtask

    // Sync after a random gap, then every enabled cycle against the segment rules
    task automatic run_slice(input int n_cycles, input bit full);
        int       c;
        int       n;
        int       row;
        int       widx;
        int       sclk_n;
        int       gclk_n;
        int       lat_n;
        int       lat_grp_n;
        int       colr_n;
        bit       found;
        bit       data_cyc;
        bit       lat_exp;
        bit       lat_prev;
        logic [3:0] exp;
        repeat ($urandom % 32 + 1) @(posedge clk);
        position_sync <= 1'b1;
        @(posedge clk);
        position_sync <= 1'b0;
        found = 1'b0;
        for (n = 0; n < 8 && !found; n++) begin
            next_enabled();
            found = drv_gclk;
        end
        if (!found) begin
            report_problem("no GCLK after position_sync");
            return;
        end
        // First GCLK marks count 1 of row 0
        c = 1;
        row = 0;
        widx = 0;
        colr_n = 0;
        sclk_n = 0;
        gclk_n = 0;
        lat_n = 0;
        lat_grp_n = 0;
        lat_prev = 1'b0;
        for (n = 0; n < n_cycles && row < `POV_ROWS; n++) begin
            if (n > 0) begin
                next_enabled();
            end
            data_cyc = (c > `POV_BLANK) && ((c - `POV_BLANK) % GROUP_LEN != 0);
            lat_exp  = ((c > `POV_BLANK) && ((c - `POV_BLANK) % GROUP_LEN == `POV_WORD_BITS))
                       || (c > `POV_SEG_LAST - `POV_LATGS_LEN);
            exp = {data_cyc, c != 0, lat_exp, c == `POV_SEG_LAST};
            if ({drv_sclk, drv_gclk, drv_lat, column_ready} !== exp) begin
                report_mismatch(0, $sformatf("row %0d count %0d SCLK/GCLK/LAT/COL %b, expected %b",
                                             row, c, {drv_sclk, drv_gclk, drv_lat, column_ready},
                                             exp));
            end
            if (drv_sclk === 1'b1) begin
                if (widx < `POV_SLICE_WORDS && drv_sin !== model_buf[widx]) begin
                    report_mismatch(1, $sformatf("word %0d SIN %h, expected %h",
                                                 widx, drv_sin, model_buf[widx]));
                end
                widx++;
                sclk_n++;
            end
            // One LAT pulse per group, the last one stretched into LATGS
            if (drv_lat === 1'b1 && !lat_prev) begin
                lat_grp_n++;
            end
            lat_prev = (drv_lat === 1'b1);
            gclk_n += drv_gclk;
            lat_n  += drv_lat;
            colr_n += column_ready;
            if (c == `POV_SEG_LAST) begin
                if (sclk_n != `POV_WORD_BITS * `POV_GROUPS || gclk_n != `POV_SEG_LAST
                    || lat_grp_n != `POV_GROUPS
                    || lat_n != `POV_GROUPS + `POV_LATGS_LEN - 1) begin
                    report_mismatch(0, $sformatf("row %0d SCLK %0d GCLK %0d LAT pulses %0d LAT %0d",
                                                 row, sclk_n, gclk_n, lat_grp_n, lat_n));
                end
                sclk_n = 0;
                gclk_n = 0;
                lat_n = 0;
                lat_grp_n = 0;
                row++;
                c = 0;
            end else begin
                c++;
            end
        end
        if (full) begin
            if (widx != `POV_SLICE_WORDS) begin
                report_mismatch(1, $sformatf("slice carried %0d words", widx));
            end
            if (colr_n != `POV_ROWS) begin
                report_mismatch(0, $sformatf("column_ready pulsed %0d times", colr_n));
            end
            // Drivers stay quiet until the next sync
            for (n = 0; n < IDLE_CYCLES; n++) begin
                next_enabled();
                if ({drv_sclk, drv_gclk, drv_lat, column_ready} !== 4'b0000) begin
                    report_mismatch(0, "driver clocks active after slice end");
                end
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] w;
        int unsigned addr;
        int          e0;
        int          d0;
        int          t0;
        int          i;
        clk           = 1'b0;
        nrst          = 1'b0;
        clk_enable    = 1'b0;
        position_sync = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        err_cnt       = 0;
        data_errs     = 0;
        time_errs     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        void'($urandom(32'h41da_32f9));
        repeat (10) @(posedge clk);
        nrst <= 1'b1;

        // Reset values and bus errors
        e0 = err_cnt;
        next_enabled();
        if ({drv_sclk, drv_gclk, drv_lat, column_ready, configured} !== 5'b0
            || drv_sin !== '0) begin
            report_mismatch(0, "driver outputs not low after reset");
        end
        apb_read_check(`POV_REG_CONF_LO, 32'h0);
        apb_read_check(`POV_REG_CONF_HI, 32'h0);
        apb_read_check(`POV_REG_STATUS, 32'h0);
        apb_access(1'b0, 8'h20, 32'h0, rd, err);
        if (err !== 1'b1) begin
            report_mismatch(0, "no pslverr on read of unmapped 0x20");
        end
        apb_access(1'b1, `POV_REG_STATUS, 32'h1, rd, err);
        if (err !== 1'b1) begin
            report_mismatch(0, "no pslverr on write to STATUS");
        end
        apb_read_check(`POV_REG_STATUS, 32'h0);
        finish_test(1, "reset and register access", err_cnt - e0);

        e0 = err_cnt;
        load_config();
        finish_test(2, "configuration sequence", err_cnt - e0);

        // One slice covers the data and the timing tests
        d0 = data_errs;
        t0 = time_errs;
        fill_buffer();
        run_slice(`POV_ROWS * SEG_LEN, 1'b1);
        finish_test(3, "slice data", data_errs - d0);
        finish_test(4, "segment timing", time_errs - t0);

        // Scattered rewrites, then a commit in the middle of a slice
        e0 = err_cnt;
        for (i = 0; i < 16; i++) begin
            addr = $urandom % (`POV_SLICE_WORDS - 1);
            w = $urandom;
            apb_write(`POV_REG_BUF_ADDR, addr);
            apb_write(`POV_REG_BUF_DATA, w);
            model_buf[addr] = w[`POV_LANES-1:0];
            apb_read_check(`POV_REG_BUF_ADDR, addr + 1);
        end
        run_slice(3 * SEG_LEN + 200, 1'b0);
        load_config();
        run_slice(`POV_ROWS * SEG_LEN, 1'b1);
        finish_test(5, "commit during stream", err_cnt - e0);

        $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(RUN_CLKS * CLK_PERIOD);
        $display("Watchdog expired after %0d clk cycles, the run did not finish", RUN_CLKS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/pov_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pov_consts.svh"

module pov_apb_regs
    import pov_bus_pkg::*;
    import pov_drv_pkg::*;
(
    input  wire                     clk,
    input  wire                     nrst,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire [`POV_APB_AW-1:0]   paddr,
    input  wire [`POV_APB_DW-1:0]   pwdata,
    output logic [`POV_APB_DW-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  wire                     configured,
    output conf_word_t              conf_word,
    output logic                    conf_commit,
    output logic                    buf_wr_en,
    output logic [`POV_BUF_AW-1:0]  buf_wr_addr,
    output lane_word_t              buf_wr_data
);

    conf_half_t             conf_lo;
    conf_half_t             conf_hi;
    logic [`POV_BUF_AW-1:0] wr_ptr;
    logic [`POV_BUF_AW-1:0] wr_ptr_next;
    logic                   access;
    logic                   addr_hit;
    logic                   wr_access;

    // Access phase of an APB transfer
    assign access = psel & penable;

    // No wait states
    assign pready = 1'b1;

    always_comb begin
        case (paddr)
            REG_CONF_LO, REG_CONF_HI, REG_CTRL,
            REG_STATUS, REG_BUF_ADDR, REG_BUF_DATA: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    // Unmapped offset or write to the read-only status
    assign pslverr = access & (~addr_hit | (pwrite & (paddr == REG_STATUS)));

    // Erroring writes change nothing
    assign wr_access = access & pwrite & ~pslverr;

    // Buffer pointer wraps at the slice depth
    assign wr_ptr_next = (wr_ptr == `POV_SLICE_WORDS - 1) ? '0 : wr_ptr + 1'b1;

    // Two halves form the word seen by the controller
    assign conf_word = {conf_hi, conf_lo};

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            conf_lo     <= '0;
            conf_hi     <= '0;
            wr_ptr      <= '0;
            conf_commit <= 1'b0;
            buf_wr_en   <= 1'b0;
        end else begin
            // Strobes last one clk
            conf_commit <= 1'b0;
            buf_wr_en   <= 1'b0;
            if (wr_access) begin
                case (paddr)
                    REG_CONF_LO:  conf_lo <= pwdata[`POV_CONF_HALF-1:0];
                    REG_CONF_HI:  conf_hi <= pwdata[`POV_CONF_HALF-1:0];
                    REG_CTRL:     conf_commit <= pwdata[0];
                    REG_BUF_ADDR: wr_ptr <= pwdata[`POV_BUF_AW-1:0];
                    REG_BUF_DATA: begin
                        buf_wr_en <= 1'b1;
                        wr_ptr    <= wr_ptr_next;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Address and data captured with the strobe
    always_ff @(posedge clk) begin
        if (wr_access && (paddr == REG_BUF_DATA)) begin
            buf_wr_addr <= wr_ptr;
            buf_wr_data <= pwdata[`POV_LANES-1:0];
        end
    end

    // Read mux, zero outside a read access
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_CONF_LO:  prdata[`POV_CONF_HALF-1:0] = conf_lo;
                REG_CONF_HI:  prdata[`POV_CONF_HALF-1:0] = conf_hi;
                REG_STATUS:   prdata[0] = configured;
                REG_BUF_ADDR: prdata[`POV_BUF_AW-1:0] = wr_ptr;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pov_bus_pkg.sv ====
`default_nettype none

`include "pov_consts.svh"

package pov_bus_pkg;

    // Full driver configuration word
    // Shifted out MSB first on every lane
    typedef logic [`POV_CONF_BITS-1:0] conf_word_t;

    // One APB-visible half of the configuration word
    typedef logic [`POV_CONF_HALF-1:0] conf_half_t;

    // Byte offsets of the host registers
    typedef enum logic [`POV_APB_AW-1:0] {
        // Lower 24 configuration bits
        REG_CONF_LO  = `POV_REG_CONF_LO,
        // Upper 24 configuration bits
        REG_CONF_HI  = `POV_REG_CONF_HI,
        // Bit 0 commits the configuration
        REG_CTRL     = `POV_REG_CTRL,
        // Read only, bit 0 is configured
        REG_STATUS   = `POV_REG_STATUS,
        // Buffer write pointer
        REG_BUF_ADDR = `POV_REG_BUF_ADDR,
        // Buffer data port, auto increment
        REG_BUF_DATA = `POV_REG_BUF_DATA
    } reg_index_t;

endpackage

`default_nettype wire

// ==== rtl/pov_consts.svh ====
`ifndef POV_CONSTS_SVH
`define POV_CONSTS_SVH

// One SIN lane per driver chain
`define POV_LANES        30

// Driver configuration word and its two APB halves
`define POV_CONF_BITS    48
`define POV_CONF_HALF    24

// Segment geometry in SCLK-rate cycles
`define POV_SEG_LAST     512
`define POV_BLANK        72
`define POV_WORD_BITS    48
`define POV_GROUPS       9
`define POV_LATGS_LEN    3

// Slice geometry
`define POV_ROWS         8
`define POV_SLICE_WORDS  (`POV_WORD_BITS * `POV_GROUPS * `POV_ROWS)
`define POV_BUF_AW       12

// Configuration sequence lengths
`define POV_PREP_CYCLES  15
`define POV_WRTFC_LEN    5
`define POV_WAIT_CYCLES  6

// APB bus widths and register map
`define POV_APB_AW       8
`define POV_APB_DW       32
`define POV_REG_CONF_LO  8'h00
`define POV_REG_CONF_HI  8'h04
`define POV_REG_CTRL     8'h08
`define POV_REG_STATUS   8'h0C
`define POV_REG_BUF_ADDR 8'h10
`define POV_REG_BUF_DATA 8'h14

`endif

// ==== rtl/pov_drv_pkg.sv ====
`default_nettype none

`include "pov_consts.svh"

package pov_drv_pkg;

    // Driver controller states
    // Boot path runs STALL, PREPARE_CONFIG, CONFIG, WRTFC_TIMING
    // then alternates WAIT_FOR_NEXT_SLICE and STREAM
    typedef enum logic [2:0] {
        STALL,
        PREPARE_CONFIG,
        CONFIG,
        WRTFC_TIMING,
        WAIT_FOR_NEXT_SLICE,
        STREAM
    } drv_state_t;

    // One bit per driver chain, sent on SIN in parallel
    typedef logic [`POV_LANES-1:0] lane_word_t;

endpackage

`default_nettype wire

// ==== rtl/pov_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pov_consts.svh"

module pov_top
    import pov_bus_pkg::*;
    import pov_drv_pkg::*;
(
    input  wire                     clk,
    input  wire                     nrst,
    input  wire                     clk_enable,
    input  wire                     position_sync,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire [`POV_APB_AW-1:0]   paddr,
    input  wire [`POV_APB_DW-1:0]   pwdata,
    output logic [`POV_APB_DW-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    drv_sclk,
    output logic                    drv_gclk,
    output logic                    drv_lat,
    output lane_word_t              drv_sin,
    output logic                    column_ready,
    output logic                    configured
);

    // Host to controller
    conf_word_t             conf_word;
    logic                   conf_commit;

    // Host to slice buffer
    logic                   buf_wr_en;
    logic [`POV_BUF_AW-1:0] buf_wr_addr;
    lane_word_t             buf_wr_data;

    // Slice buffer to controller
    lane_word_t             fb_dat;
    logic                   driver_ready;
    logic                   slice_start;

    pov_apb_regs regs_i (
        .clk         (clk),
        .nrst        (nrst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .configured  (configured),
        .conf_word   (conf_word),
        .conf_commit (conf_commit),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data)
    );

    tlc_driver_ctrl ctrl_i (
        .clk           (clk),
        .clk_enable    (clk_enable),
        .nrst          (nrst),
        .position_sync (position_sync),
        .conf_word     (conf_word),
        .conf_commit   (conf_commit),
        .fb_dat        (fb_dat),
        .drv_sclk      (drv_sclk),
        .drv_gclk      (drv_gclk),
        .drv_lat       (drv_lat),
        .drv_sin       (drv_sin),
        .column_ready  (column_ready),
        .driver_ready  (driver_ready),
        .slice_start   (slice_start),
        .configured    (configured)
    );

    slice_buffer buf_i (
        .clk         (clk),
        .nrst        (nrst),
        .wr_en       (buf_wr_en),
        .wr_addr     (buf_wr_addr),
        .wr_data     (buf_wr_data),
        .rd_advance  (driver_ready),
        .slice_start (slice_start),
        .rd_data     (fb_dat)
    );

endmodule

`default_nettype wire

// ==== rtl/slice_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pov_consts.svh"

module slice_buffer
    import pov_drv_pkg::*;
(
    input  wire                     clk,
    input  wire                     nrst,
    input  wire                     wr_en,
    input  wire [`POV_BUF_AW-1:0]   wr_addr,
    input  wire lane_word_t         wr_data,
    input  wire                     rd_advance,
    input  wire                     slice_start,
    output lane_word_t              rd_data
);

    // One word per data SCLK of the slice, in stream order
    lane_word_t             mem [`POV_SLICE_WORDS];
    logic [`POV_BUF_AW-1:0] rd_ptr;
    logic                   wr_in_range;

    // Pointer values past the slice are dropped
    assign wr_in_range = wr_addr < `POV_SLICE_WORDS;

    always_ff @(posedge clk) begin
        if (wr_en && wr_in_range) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read pointer follows the controller through the slice
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_ptr <= '0;
        end else if (slice_start) begin
            rd_ptr <= '0;
        end else if (rd_advance) begin
            if (rd_ptr == `POV_SLICE_WORDS - 1) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Registered read
    // word stays put until the next advance
    always_ff @(posedge clk) begin
        if (rd_advance) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tlc_driver_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pov_consts.svh"

module tlc_driver_ctrl
    import pov_bus_pkg::*;
    import pov_drv_pkg::*;
(
    input  wire         clk,
    input  wire         clk_enable,
    input  wire         nrst,
    input  wire         position_sync,
    input  wire         conf_word_t conf_word,
    input  wire         conf_commit,
    input  wire         lane_word_t fb_dat,
    output logic        drv_sclk,
    output logic        drv_gclk,
    output logic        drv_lat,
    output lane_word_t  drv_sin,
    output logic        column_ready,
    output logic        driver_ready,
    output logic        slice_start,
    output logic        configured
);

    drv_state_t  state;
    logic [5:0]  state_cnt;
    logic [9:0]  seg_cnt;
    logic [5:0]  shift_cnt;
    logic [2:0]  row_cnt;
    logic        commit_pend;
    logic        sync_pend;
    logic        sync_hit;
    logic        take_conf;
    logic        seg_end;
    logic        slice_end;
    logic        blanking;
    logic        data_slot;

    // Commit is taken only from the idle, waiting and streaming states
    assign take_conf = clk_enable & commit_pend
                       & ((state == STALL) | (state == WAIT_FOR_NEXT_SLICE)
                          | (state == STREAM));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            commit_pend <= 1'b0;
            sync_pend   <= 1'b0;
        end else begin
            if (conf_commit) begin
                commit_pend <= 1'b1;
            end else if (take_conf) begin
                commit_pend <= 1'b0;
            end
            // Sync seen between enables is held for the next enabled cycle
            sync_pend <= sync_hit & ~clk_enable;
        end
    end

    assign sync_hit = position_sync | sync_pend;

    // Segment and slice boundaries
    assign seg_end   = (state == STREAM) && (seg_cnt == `POV_SEG_LAST);
    assign slice_end = seg_end && (row_cnt == `POV_ROWS - 1);

    // Blanking covers the first 72 counts of a segment
    assign blanking  = seg_cnt < `POV_BLANK;

    // Data SCLK slots, count 72 and every 49th after it are pauses for WRTGS
    assign data_slot = (state == STREAM) && !blanking && (shift_cnt != 0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= STALL;
            state_cnt  <= '0;
            configured <= 1'b0;
        end else if (clk_enable) begin
            case (state)
                STALL: begin
                    if (commit_pend) begin
                        state     <= PREPARE_CONFIG;
                        state_cnt <= '0;
                    end
                end

                PREPARE_CONFIG: begin
                    // FCWRTEN, LAT held for 15 cycles
                    if (state_cnt == `POV_PREP_CYCLES - 1) begin
                        state     <= CONFIG;
                        state_cnt <= '0;
                    end else begin
                        state_cnt <= state_cnt + 1'b1;
                    end
                end

                CONFIG: begin
                    // One pause cycle then 48 configuration bits
                    if (state_cnt == `POV_CONF_BITS) begin
                        state     <= WRTFC_TIMING;
                        state_cnt <= '0;
                    end else begin
                        state_cnt <= state_cnt + 1'b1;
                    end
                end

                WRTFC_TIMING: begin
                    // Gap after WRTFC before the drivers take GS data
                    if (state_cnt == `POV_WAIT_CYCLES - 1) begin
                        state      <= WAIT_FOR_NEXT_SLICE;
                        state_cnt  <= '0;
                        configured <= 1'b1;
                    end else begin
                        state_cnt <= state_cnt + 1'b1;
                    end
                end

                WAIT_FOR_NEXT_SLICE: begin
                    // New configuration wins over a sync
                    if (commit_pend) begin
                        state      <= PREPARE_CONFIG;
                        state_cnt  <= '0;
                        configured <= 1'b0;
                    end else if (sync_hit) begin
                        state <= STREAM;
                    end
                end

                STREAM: begin
                    // Commit aborts the running slice
                    if (commit_pend) begin
                        state      <= PREPARE_CONFIG;
                        state_cnt  <= '0;
                        configured <= 1'b0;
                    end else if (slice_end) begin
                        state <= WAIT_FOR_NEXT_SLICE;
                    end
                end

                default: begin
                    state     <= STALL;
                    state_cnt <= '0;
                end
            endcase
        end
    end

    // Segment, group phase and row counters, all idle at zero outside STREAM
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            seg_cnt   <= '0;
            shift_cnt <= '0;
            row_cnt   <= '0;
        end else if (clk_enable) begin
            if (state == STREAM) begin
                seg_cnt <= seg_end ? '0 : seg_cnt + 1'b1;
                if (blanking || (shift_cnt == `POV_WORD_BITS)) begin
                    shift_cnt <= '0;
                end else begin
                    shift_cnt <= shift_cnt + 1'b1;
                end
                if (seg_end) begin
                    row_cnt <= slice_end ? '0 : row_cnt + 1'b1;
                end
            end else begin
                seg_cnt   <= '0;
                shift_cnt <= '0;
                row_cnt   <= '0;
            end
        end
    end

    // SCLK pulses one clk per enabled cycle
    always_comb begin
        case (state)
            CONFIG:  drv_sclk = clk_enable & (state_cnt != 0);
            STREAM:  drv_sclk = clk_enable & data_slot;
            default: drv_sclk = 1'b0;
        endcase
    end

    // GCLK paused at count 0 after LATGS
    assign drv_gclk = clk_enable & (state == STREAM) & (seg_cnt != 0);

    // LAT commands: FCWRTEN, WRTFC on the last 5 bits, WRTGS per group, LATGS at the end
    always_comb begin
        case (state)
            PREPARE_CONFIG: drv_lat = 1'b1;
            CONFIG: begin
                drv_lat = state_cnt >= (`POV_CONF_BITS + 1 - `POV_WRTFC_LEN);
            end
            STREAM: begin
                drv_lat = (shift_cnt == `POV_WORD_BITS)
                          || (seg_cnt > `POV_SEG_LAST - `POV_LATGS_LEN);
            end
            default: drv_lat = 1'b0;
        endcase
    end

    // Same configuration bit on every lane, MSB first
    always_comb begin
        drv_sin = '0;
        if ((state == CONFIG) && (state_cnt != 0)) begin
            drv_sin = {`POV_LANES{conf_word[`POV_CONF_BITS - state_cnt]}};
        end else if (state == STREAM) begin
            drv_sin = fb_dat;
        end
    end

    assign column_ready = clk_enable & seg_end;

    // Counters already hold the values of the coming enabled cycle
    assign driver_ready = ~clk_enable & data_slot;

    assign slice_start = clk_enable & (state == WAIT_FOR_NEXT_SLICE) & sync_hit & ~commit_pend;

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/pov_bus_pkg.sv
rtl/pov_drv_pkg.sv
rtl/pov_apb_regs.sv
rtl/tlc_driver_ctrl.sv
rtl/slice_buffer.sv
rtl/pov_top.sv
bench/tb_pov_top.sv
